// ==== Makefile ====
.PHONY: all run clean

all: run

obj_dir/Vtb: tb.f $(shell cat tb.f)
	verilator --binary --timing --assert -Wno-fatal --top-module tb -f tb.f

run: obj_dir/Vtb
	@out=$$(./obj_dir/Vtb +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

// ==== design/controlUnit.sv ====
`timescale 1ns/10ps

module controlUnit #(
    parameter bit hasMulDiv = 1'b1
) (
    input  logic [31:0]          instr,
    output corePipePkg::ctrlT    ctrl,
    output rvIsaPkg::branchCondT branchCond
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Only meaningful for branches, execute ignores it otherwise
    assign branchCond = rvIsaPkg::branchCondT'(funct3);

    always_comb begin
        ctrl = '0;
        ctrl.aluOp  = rvIsaPkg::aluAdd;
        ctrl.immSel = rvIsaPkg::immI;

        case (opcode)
            rvIsaPkg::opR: begin
                ctrl.regWrite = 1'b1;
                case (funct7)
                    7'b0000000: begin
                        case (funct3)
                            3'b000: ctrl.aluOp = rvIsaPkg::aluAdd;
                            3'b001: ctrl.aluOp = rvIsaPkg::aluSll;
                            3'b010: ctrl.aluOp = rvIsaPkg::aluSlt;
                            3'b011: ctrl.aluOp = rvIsaPkg::aluSltu;
                            3'b100: ctrl.aluOp = rvIsaPkg::aluXor;
                            3'b101: ctrl.aluOp = rvIsaPkg::aluSrl;
                            3'b110: ctrl.aluOp = rvIsaPkg::aluOr;
                            default: ctrl.aluOp = rvIsaPkg::aluAnd;
                        endcase
                    end
                    7'b0100000: begin
                        case (funct3)
                            3'b000: ctrl.aluOp = rvIsaPkg::aluSub;
                            3'b101: ctrl.aluOp = rvIsaPkg::aluSra;
                            default: ctrl.illegal = 1'b1;
                        endcase
                    end
                    7'b0000001: begin
                        // M subset, signed forms only
                        case (funct3)
                            3'b000: ctrl.aluOp = rvIsaPkg::aluMul;
                            3'b001: ctrl.aluOp = rvIsaPkg::aluMulh;
                            3'b100: ctrl.aluOp = rvIsaPkg::aluDiv;
                            3'b110: ctrl.aluOp = rvIsaPkg::aluRem;
                            default: ctrl.illegal = 1'b1;
                        endcase
                        if (!hasMulDiv) ctrl.illegal = 1'b1;
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            rvIsaPkg::opImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.srcBImm  = 1'b1;
                case (funct3)
                    3'b000: ctrl.aluOp = rvIsaPkg::aluAdd;
                    3'b010: ctrl.aluOp = rvIsaPkg::aluSlt;
                    3'b011: ctrl.aluOp = rvIsaPkg::aluSltu;
                    3'b100: ctrl.aluOp = rvIsaPkg::aluXor;
                    3'b110: ctrl.aluOp = rvIsaPkg::aluOr;
                    3'b111: ctrl.aluOp = rvIsaPkg::aluAnd;
                    3'b001: begin
                        ctrl.aluOp   = rvIsaPkg::aluSll;
                        ctrl.illegal = (funct7 != 7'b0000000);
                    end
                    default: begin // Shift right, funct7 picks srai
                        if (funct7 == 7'b0000000) ctrl.aluOp = rvIsaPkg::aluSrl;
                        else if (funct7 == 7'b0100000) ctrl.aluOp = rvIsaPkg::aluSra;
                        else ctrl.illegal = 1'b1;
                    end
                endcase
            end
            rvIsaPkg::opBranch: begin
                ctrl.isBranch = 1'b1;
                ctrl.immSel   = rvIsaPkg::immB;
                ctrl.illegal  = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            rvIsaPkg::opJal: begin
                ctrl.regWrite   = 1'b1;
                ctrl.isJump     = 1'b1;
                ctrl.linkResult = 1'b1;
                ctrl.immSel     = rvIsaPkg::immJ;
            end
            rvIsaPkg::opJalr: begin
                ctrl.regWrite   = 1'b1;
                ctrl.isJump     = 1'b1;
                ctrl.jumpReg    = 1'b1;
                ctrl.linkResult = 1'b1;
                ctrl.illegal    = (funct3 != 3'b000);
            end
            rvIsaPkg::opLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = rvIsaPkg::aluPassB;
                ctrl.srcBImm  = 1'b1;
                ctrl.immSel   = rvIsaPkg::immU;
            end
            rvIsaPkg::opAuipc: begin
                ctrl.regWrite = 1'b1;
                ctrl.srcAPc   = 1'b1;
                ctrl.srcBImm  = 1'b1;
                ctrl.immSel   = rvIsaPkg::immU;
            end
            rvIsaPkg::opLoad, rvIsaPkg::opStore, rvIsaPkg::opSystem: begin
                ctrl.illegal = 1'b1; // No memory or trap support
            end
            default: ctrl.illegal = 1'b1;
        endcase

        if (ctrl.illegal) ctrl.regWrite = 1'b0;
    end

endmodule

// ==== design/corePipePkg.sv ====
package corePipePkg;

    typedef struct packed {
        logic [31:0] word;
        logic [31:0] pc;
    } instrInT;

    typedef struct packed {
        logic             regWrite;
        rvIsaPkg::aluOpT  aluOp;
        logic             srcAPc;      // auipc uses pc as operand A
        logic             srcBImm;
        rvIsaPkg::immSelT immSel;
        logic             isBranch;
        logic             isJump;
        logic             jumpReg;     // jalr
        logic             linkResult;  // Result is pc+4
        logic             illegal;
    } ctrlT;

    // Record held between decode and execute
    typedef struct packed {
        logic [31:0]          pc;
        ctrlT                 ctrl;
        logic [4:0]           rd;
        logic [31:0]          rs1Val;
        logic [31:0]          rs2Val;
        logic [31:0]          imm;
        rvIsaPkg::branchCondT branchCond;
    } decodedT;

    typedef struct packed {
        logic        writeEn;
        logic [4:0]  rd;
        logic [31:0] value;
    } bypassT;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        writeEn;
        logic [31:0] result;
        logic        taken;
        logic [31:0] nextPc;
        logic        illegal;
    } retireT;

endpackage

// ==== design/coreTop.sv ====
`timescale 1ns/10ps

module coreTop #(
    parameter bit hasMulDiv = 1'b1
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instrValid,
    input  corePipePkg::instrInT instr,
    output logic                 retireValid,
    output corePipePkg::retireT  retire
);

    logic                 decValid;
    corePipePkg::decodedT dec;
    corePipePkg::bypassT  wb;
    logic [4:0]           rs1Addr;
    logic [4:0]           rs2Addr;
    logic [31:0]          rs1Data;
    logic [31:0]          rs2Data;

    decodeStage #(.hasMulDiv(hasMulDiv)) decode_i (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .wb         (wb),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .decValid   (decValid),
        .dec        (dec)
    );

    executeStage #(.hasMulDiv(hasMulDiv)) execute_i (
        .clk         (clk),
        .rstN        (rstN),
        .decValid    (decValid),
        .dec         (dec),
        .wb          (wb),
        .retireValid (retireValid),
        .retire      (retire)
    );

    regFile regs_i (
        .clk     (clk),
        .rstN    (rstN),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wb      (wb)
    );

endmodule

// ==== design/decodeStage.sv ====
`timescale 1ns/10ps

module decodeStage #(
    parameter bit hasMulDiv = 1'b1
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instrValid,
    input  corePipePkg::instrInT instr,
    input  corePipePkg::bypassT  wb,
    output logic [4:0]           rs1Addr,
    output logic [4:0]           rs2Addr,
    input  logic [31:0]          rs1Data,
    input  logic [31:0]          rs2Data,
    output logic                 decValid,
    output corePipePkg::decodedT dec
);

    corePipePkg::ctrlT    ctrl;
    rvIsaPkg::branchCondT branchCond;
    logic [31:0]          imm;
    logic [31:0]          rs1Val;
    logic [31:0]          rs2Val;
    logic [31:0]          iw;

    assign iw = instr.word;

    controlUnit #(.hasMulDiv(hasMulDiv)) control_i (
        .instr      (iw),
        .ctrl       (ctrl),
        .branchCond (branchCond)
    );

    // Sign-extended immediate per format
    always_comb begin
        case (ctrl.immSel)
            rvIsaPkg::immI: imm = {{20{iw[31]}}, iw[31:20]};
            rvIsaPkg::immS: imm = {{20{iw[31]}}, iw[31:25], iw[11:7]};
            rvIsaPkg::immB: imm = {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
            rvIsaPkg::immU: imm = {iw[31:12], 12'd0};
            rvIsaPkg::immJ: imm = {{11{iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};
            default:        imm = 32'd0;
        endcase
    end

    assign rs1Addr = iw[19:15];
    assign rs2Addr = iw[24:20];

    // Execute result lands in the file at the same edge, so take it from wb
    assign rs1Val = (wb.writeEn && (wb.rd == rs1Addr) && (rs1Addr != 5'd0)) ? wb.value : rs1Data;
    assign rs2Val = (wb.writeEn && (wb.rd == rs2Addr) && (rs2Addr != 5'd0)) ? wb.value : rs2Data;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) decValid <= 1'b0;
        else       decValid <= instrValid;
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            dec.pc         <= instr.pc;
            dec.ctrl       <= ctrl;
            dec.rd         <= iw[11:7];
            dec.rs1Val     <= rs1Val;
            dec.rs2Val     <= rs2Val;
            dec.imm        <= imm;
            dec.branchCond <= branchCond;
        end
    end

endmodule

// ==== design/executeStage.sv ====
`timescale 1ns/10ps

module executeStage #(
    parameter bit hasMulDiv = 1'b1
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 decValid,
    input  corePipePkg::decodedT dec,
    output corePipePkg::bypassT  wb,
    output logic                 retireValid,
    output corePipePkg::retireT  retire
);

    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluOut;
    logic [31:0] mulLo;
    logic [31:0] mulHi;
    logic [31:0] divQ;
    logic [31:0] divR;
    logic        eq;
    logic        ltS;
    logic        ltU;
    logic        condMet;
    logic        taken;
    logic [31:0] pcPlus4;
    logic [31:0] target;
    logic [31:0] nextPc;
    logic [31:0] result;
    logic        wrEn;

    assign opA = dec.ctrl.srcAPc ? dec.pc : dec.rs1Val;
    assign opB = dec.ctrl.srcBImm ? dec.imm : dec.rs2Val;

    generate
        if (hasMulDiv) begin : genMulDiv
            logic signed [31:0] aS;
            logic signed [31:0] bS;
            logic signed [63:0] prod;
            logic signed [31:0] quotS;
            logic signed [31:0] remS;
            logic               divZero;
            logic               divOvf;

            assign aS   = opA;
            assign bS   = opB;
            assign prod = aS * bS;
            assign mulLo = prod[31:0];
            assign mulHi = prod[63:32];

            // Signed divide kept apart from the unsigned corner constants
            assign quotS = aS / bS;
            assign remS  = aS % bS;

            assign divZero = (opB == 32'd0);
            assign divOvf  = (opA == 32'h8000_0000) && (opB == 32'hFFFF_FFFF);
            // RISC-V corner results, no trap
            assign divQ = divZero ? 32'hFFFF_FFFF : divOvf ? 32'h8000_0000 : quotS;
            assign divR = divZero ? opA : divOvf ? 32'd0 : remS;
        end else begin : genNoMulDiv
            assign mulLo = 32'd0;
            assign mulHi = 32'd0;
            assign divQ  = 32'd0;
            assign divR  = 32'd0;
        end
    endgenerate

    always_comb begin
        case (dec.ctrl.aluOp)
            rvIsaPkg::aluAdd:   aluOut = opA + opB;
            rvIsaPkg::aluSub:   aluOut = opA - opB;
            rvIsaPkg::aluSll:   aluOut = opA << opB[4:0];
            rvIsaPkg::aluSlt:   aluOut = {31'd0, $signed(opA) < $signed(opB)};
            rvIsaPkg::aluSltu:  aluOut = {31'd0, opA < opB};
            rvIsaPkg::aluXor:   aluOut = opA ^ opB;
            rvIsaPkg::aluSrl:   aluOut = opA >> opB[4:0];
            rvIsaPkg::aluSra:   aluOut = $signed(opA) >>> opB[4:0];
            rvIsaPkg::aluOr:    aluOut = opA | opB;
            rvIsaPkg::aluAnd:   aluOut = opA & opB;
            rvIsaPkg::aluMul:   aluOut = mulLo;
            rvIsaPkg::aluMulh:  aluOut = mulHi;
            rvIsaPkg::aluDiv:   aluOut = divQ;
            rvIsaPkg::aluRem:   aluOut = divR;
            default:            aluOut = opB; // aluPassB
        endcase
    end

    // Branch compare always on the register values
    assign eq  = (dec.rs1Val == dec.rs2Val);
    assign ltS = $signed(dec.rs1Val) < $signed(dec.rs2Val);
    assign ltU = dec.rs1Val < dec.rs2Val;

    always_comb begin
        case (dec.branchCond)
            rvIsaPkg::brEq:  condMet = eq;
            rvIsaPkg::brNe:  condMet = !eq;
            rvIsaPkg::brLt:  condMet = ltS;
            rvIsaPkg::brGe:  condMet = !ltS;
            rvIsaPkg::brLtu: condMet = ltU;
            rvIsaPkg::brGeu: condMet = !ltU;
            default:         condMet = 1'b0;
        endcase
    end

    assign taken   = !dec.ctrl.illegal && (dec.ctrl.isJump || (dec.ctrl.isBranch && condMet));
    assign pcPlus4 = dec.pc + 32'd4;
    assign target  = dec.ctrl.jumpReg ? ((dec.rs1Val + dec.imm) & ~32'd1) : dec.pc + dec.imm;
    assign nextPc  = taken ? target : pcPlus4;

    assign result = dec.ctrl.illegal ? 32'd0 : dec.ctrl.linkResult ? pcPlus4 : aluOut;
    assign wrEn   = dec.ctrl.regWrite && (dec.rd != 5'd0) && !dec.ctrl.illegal;

    // Write port and bypass source
    assign wb.writeEn = decValid && wrEn;
    assign wb.rd      = dec.rd;
    assign wb.value   = result;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) retireValid <= 1'b0;
        else       retireValid <= decValid;
    end

    always_ff @(posedge clk) begin
        if (decValid) begin
            retire.pc      <= dec.pc;
            retire.rd      <= dec.rd;
            retire.writeEn <= wrEn;
            retire.result  <= result;
            retire.taken   <= taken;
            retire.nextPc  <= nextPc;
            retire.illegal <= dec.ctrl.illegal;
        end
    end

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/10ps

module regFile (
    input  logic                clk,
    input  logic                rstN,
    input  logic [4:0]          rs1Addr,
    input  logic [4:0]          rs2Addr,
    output logic [31:0]         rs1Data,
    output logic [31:0]         rs2Data,
    input  corePipePkg::bypassT wb
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.writeEn && (wb.rd != 5'd0)) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // Combinational reads
    assign rs1Data = (rs1Addr == 5'd0) ? 32'd0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? 32'd0 : regs[rs2Addr];

endmodule

// ==== design/rvIsaPkg.sv ====
package rvIsaPkg;

    // Major opcodes, instr[6:0]
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opSystem = 7'b1110011;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluMul,
        aluMulh,
        aluDiv,
        aluRem,
        aluPassB    // lui result is the immediate itself
    } aluOpT;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ
    } immSelT;

    // Values match funct3 of the branch encodings
    typedef enum logic [2:0] {
        brEq  = 3'b000,
        brNe  = 3'b001,
        brLt  = 3'b100,
        brGe  = 3'b101,
        brLtu = 3'b110,
        brGeu = 3'b111
    } branchCondT;

endpackage

// ==== sim/retire_checker.sv ====
`timescale 1ns/10ps

module retireChecker (
    input logic                clk,
    input logic                rstN,
    input logic                instrValid,
    input logic                retireValid,
    input corePipePkg::retireT retire
);

    int assertFails = 0;

    // Fixed two-cycle latency, both directions
    latencyFwd: assert property (@(posedge clk) disable iff (!rstN)
        instrValid |-> ##2 retireValid)
        else begin
            $error("retireValid missing two cycles after instrValid");
            assertFails++;
        end

    latencyBack: assert property (@(posedge clk) disable iff (!rstN)
        retireValid |-> $past(instrValid, 2))
        else begin
            $error("retireValid without instrValid two cycles before");
            assertFails++;
        end

    quietAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !retireValid)
        else begin
            $error("retireValid high right after reset release");
            assertFails++;
        end

    cleanWrite: assert property (@(posedge clk) disable iff (!rstN)
        retireValid |-> !(retire.writeEn && ((retire.rd == 5'd0) || retire.illegal)))
        else begin
            $error("writeEn set with rd zero or on an illegal instruction");
            assertFails++;
        end

endmodule

bind coreTop retireChecker check_i (
    .clk         (clk),
    .rstN        (rstN),
    .instrValid  (instrValid),
    .retireValid (retireValid),
    .retire      (retire)
);

// ==== sim/tb.sv ====
`timescale 1ns/10ps

module tb;

    localparam int maxCycles = 400; // Tests take about 150 cycles, rest is margin

    logic                 clk = 1'b0;
    logic                 rstN;
    logic                 instrValid;
    corePipePkg::instrInT instr;
    logic                 retireValid;
    corePipePkg::retireT  retire;

    logic [31:0]         shadow [32];      // Reference register file
    corePipePkg::retireT expQ [$];
    logic [31:0]         curPc = 32'h0000_1000;
    string               testName = "reset";
    int                  errors = 0;
    int                  cycles;
    int                  seed = 36;

    coreTop #(.hasMulDiv(1'b1)) dut_i (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .retireValid (retireValid),
        .retire      (retire)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] rType(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] iType(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] bType(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rvIsaPkg::opBranch};
    endfunction

    function automatic logic [31:0] uType(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jType(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rvIsaPkg::opJal};
    endfunction

    function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] mulDivRef(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        logic [63:0] prod;
        logic        ovf;
        prod = {{32{a[31]}}, a} * {{32{b[31]}}, b}; // Low 64 bits equal the signed product
        ovf  = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
        case (f3)
            3'd0: return prod[31:0];
            3'd1: return prod[63:32];
            3'd4: return (b == 32'd0) ? 32'hFFFF_FFFF : ovf ? 32'h8000_0000 :
                         32'($signed(a) / $signed(b));
            default: return (b == 32'd0) ? a : ovf ? 32'd0 : 32'($signed(a) % $signed(b));
        endcase
    endfunction

    // Expected retire record from the shadow registers
    function automatic corePipePkg::retireT predict(logic [31:0] w, logic [31:0] pc);
        corePipePkg::retireT e;
        logic [31:0]         a;
        logic [31:0]         b;
        logic [31:0]         immI;
        logic [31:0]         immB;
        logic [31:0]         immJ;
        logic [2:0]          f3;
        logic                wr;
        e      = '0;
        wr     = 1'b0;
        e.pc   = pc;
        e.rd   = w[11:7];
        e.nextPc = pc + 32'd4;
        f3   = w[14:12];
        a    = shadow[w[19:15]];
        b    = shadow[w[24:20]];
        immI = {{20{w[31]}}, w[31:20]};
        immB = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        immJ = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        case (w[6:0])
            rvIsaPkg::opR: begin
                wr = 1'b1;
                e.result = w[25] ? mulDivRef(f3, a, b) : aluRef(f3, w[30], a, b);
            end
            rvIsaPkg::opImm: begin
                wr = 1'b1;
                e.result = aluRef(f3, (f3 == 3'd5) && w[30], a, immI); // Only srai alternates
            end
            rvIsaPkg::opBranch: begin
                case (f3)
                    3'd0: e.taken = (a == b);
                    3'd1: e.taken = (a != b);
                    3'd4: e.taken = $signed(a) < $signed(b);
                    3'd5: e.taken = $signed(a) >= $signed(b);
                    3'd6: e.taken = a < b;
                    default: e.taken = a >= b;
                endcase
                if (e.taken) e.nextPc = pc + immB;
            end
            rvIsaPkg::opJal: begin
                wr       = 1'b1;
                e.result = pc + 32'd4;
                e.taken  = 1'b1;
                e.nextPc = pc + immJ;
            end
            rvIsaPkg::opJalr: begin
                wr       = 1'b1;
                e.result = pc + 32'd4;
                e.taken  = 1'b1;
                e.nextPc = (a + immI) & 32'hFFFF_FFFE;
            end
            rvIsaPkg::opLui: begin
                wr       = 1'b1;
                e.result = {w[31:12], 12'd0};
            end
            rvIsaPkg::opAuipc: begin
                wr       = 1'b1;
                e.result = pc + {w[31:12], 12'd0};
            end
            default: e.illegal = 1'b1; // Loads, stores, system
        endcase
        e.writeEn = wr && (e.rd != 5'd0) && !e.illegal;
        return e;
    endfunction

    task automatic checkVal(input string field, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        if (expVal !== actVal) begin
            $display("CHECK FAILED %s %s: expected %h actual %h", testName, field, expVal, actVal);
            errors++;
        end
    endtask

    task automatic issue(input logic [31:0] w);
        corePipePkg::retireT e;
        @(posedge clk);
        instrValid <= 1'b1;
        instr      <= {w, curPc};
        e = predict(w, curPc);
        if (e.writeEn) shadow[e.rd] = e.result;
        expQ.push_back(e);
        curPc = e.nextPc; // Fetch side follows the resolved pc
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instrValid <= 1'b0;
        end
    endtask

    task automatic drain();
        int waitCycles;
        idle(1);
        waitCycles = 0;
        while ((expQ.size() != 0) && (waitCycles < 8)) begin
            @(posedge clk);
            waitCycles++;
        end
        if (expQ.size() != 0) begin
            $display("ERROR: %0d expected retires never arrived in %s", expQ.size(), testName);
            errors += expQ.size();
            expQ.delete();
        end
    endtask

    task automatic loadReg(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800; // Compensates the sign of the addi part
        issue(uType(hi[31:12], rd, rvIsaPkg::opLui));
        issue(iType(v[11:0], rd, 3'd0, rd, rvIsaPkg::opImm));
    endtask

    task automatic testAluOps();
        logic [2:0]  immOps [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        logic [31:0] r;
        int          f;
        testName = "testAluOps";
        loadReg(5'd1, $random(seed));
        loadReg(5'd2, $random(seed));
        for (f = 0; f < 8; f++) issue(rType(7'h00, 5'd2, 5'd1, f[2:0], 5'd3, rvIsaPkg::opR));
        issue(rType(7'h20, 5'd2, 5'd1, 3'd0, 5'd4, rvIsaPkg::opR)); // sub
        issue(rType(7'h20, 5'd2, 5'd1, 3'd5, 5'd5, rvIsaPkg::opR)); // sra
        foreach (immOps[i]) begin
            r = $random(seed);
            issue(iType(r[11:0], 5'd1, immOps[i], 5'd6, rvIsaPkg::opImm));
        end
        r = $random(seed);
        issue(iType({7'h00, r[4:0]}, 5'd1, 3'd1, 5'd7, rvIsaPkg::opImm));
        issue(iType({7'h00, r[9:5]}, 5'd1, 3'd5, 5'd8, rvIsaPkg::opImm));
        issue(iType({7'h20, r[14:10]}, 5'd1, 3'd5, 5'd9, rvIsaPkg::opImm));
        drain();
    endtask

    task automatic testMulDiv();
        logic [2:0] mdOps [4] = '{3'd0, 3'd1, 3'd4, 3'd6};
        testName = "testMulDiv";
        loadReg(5'd1, $random(seed));
        loadReg(5'd2, $random(seed));
        foreach (mdOps[i]) issue(rType(7'h01, 5'd2, 5'd1, mdOps[i], 5'(10 + i), rvIsaPkg::opR));
        issue(rType(7'h01, 5'd0, 5'd1, 3'd4, 5'd20, rvIsaPkg::opR)); // Divide by x0
        issue(rType(7'h01, 5'd0, 5'd1, 3'd6, 5'd21, rvIsaPkg::opR));
        loadReg(5'd22, 32'h8000_0000);
        loadReg(5'd23, 32'hFFFF_FFFF);
        issue(rType(7'h01, 5'd23, 5'd22, 3'd4, 5'd24, rvIsaPkg::opR));
        issue(rType(7'h01, 5'd23, 5'd22, 3'd6, 5'd25, rvIsaPkg::opR));
        drain();
    endtask

    // Each step reads the previous result
    task automatic runChain(input int gap);
        logic [31:0] r;
        logic [31:0] chain [6];
        r = $random(seed);
        chain[0] = iType(r[11:0], 5'd0, 3'd0, 5'd11, rvIsaPkg::opImm);
        chain[1] = rType(7'h00, 5'd11, 5'd11, 3'd0, 5'd12, rvIsaPkg::opR);
        chain[2] = rType(7'h00, 5'd11, 5'd12, 3'd4, 5'd13, rvIsaPkg::opR);
        chain[3] = rType(7'h01, 5'd13, 5'd12, 3'd0, 5'd14, rvIsaPkg::opR);
        chain[4] = iType(12'd3, 5'd14, 3'd1, 5'd15, rvIsaPkg::opImm);
        chain[5] = rType(7'h20, 5'd11, 5'd15, 3'd0, 5'd11, rvIsaPkg::opR);
        foreach (chain[i]) begin
            issue(chain[i]);
            idle(gap);
        end
        drain();
    endtask

    task automatic testBypass();
        testName = "testBypass";
        runChain(0); // Back to back, bypass path
        runChain(1); // Gaps, register file path
    endtask

    task automatic testBranches();
        logic [2:0] conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        logic [4:0] lhs [3] = '{5'd1, 5'd3, 5'd4};
        logic [4:0] rhs [3] = '{5'd2, 5'd4, 5'd3};
        testName = "testBranches";
        loadReg(5'd1, 32'd5);
        loadReg(5'd2, 32'd5);
        loadReg(5'd3, 32'hFFFF_FFFF); // Negative signed, large unsigned
        loadReg(5'd4, 32'd1);
        foreach (conds[c]) begin
            foreach (lhs[p]) issue(bType(p[0] ? 13'h1FF0 : 13'd40, rhs[p], lhs[p], conds[c]));
        end
        drain();
    endtask

    task automatic testJumpsUpper();
        logic [31:0] r;
        testName = "testJumpsUpper";
        issue(jType(21'd2048, 5'd5));
        loadReg(5'd6, 32'h0000_1001);
        issue(iType(12'd4, 5'd6, 3'd0, 5'd7, rvIsaPkg::opJalr));   // Odd target
        issue(iType(12'hFFF, 5'd6, 3'd0, 5'd0, rvIsaPkg::opJalr));
        r = $random(seed);
        issue(uType(r[31:12], 5'd8, rvIsaPkg::opLui));
        issue(uType(r[19:0], 5'd9, rvIsaPkg::opAuipc));
        issue(jType(21'h1F_FFF8, 5'd10)); // Backward
        drain();
    endtask

    task automatic testIllegal();
        testName = "testIllegal";
        issue(iType(12'd8, 5'd1, 3'b010, 5'd5, rvIsaPkg::opLoad));
        issue(rType(7'h00, 5'd2, 5'd1, 3'b010, 5'd4, rvIsaPkg::opStore));
        issue(iType(12'd0, 5'd0, 3'd0, 5'd0, rvIsaPkg::opSystem)); // ecall
        issue(iType(12'd123, 5'd1, 3'd0, 5'd0, rvIsaPkg::opImm));
        issue(rType(7'h00, 5'd0, 5'd0, 3'd0, 5'd5, rvIsaPkg::opR)); // x0 must read back zero
        drain();
    endtask

    // Retire monitor, mid-cycle sampling
    always @(negedge clk) begin
        corePipePkg::retireT e;
        if (rstN && retireValid) begin
            if (expQ.size() == 0) begin
                $display("ERROR: unexpected retire at pc %h in %s", retire.pc, testName);
                errors++;
            end else begin
                e = expQ.pop_front();
                checkVal("pc", e.pc, retire.pc);
                checkVal("writeEn", 32'(e.writeEn), 32'(retire.writeEn));
                checkVal("illegal", 32'(e.illegal), 32'(retire.illegal));
                checkVal("taken", 32'(e.taken), 32'(retire.taken));
                checkVal("nextPc", e.nextPc, retire.nextPc);
                if (e.writeEn) checkVal("rd", 32'(e.rd), 32'(retire.rd));
                if (e.writeEn || e.illegal) checkVal("result", e.result, retire.result);
            end
        end
    end

    initial begin
        for (cycles = 0; cycles < maxCycles; cycles++) @(posedge clk);
        $display("Timeout: run did not end within %0d cycles, %0d errors", cycles, errors);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        foreach (shadow[i]) shadow[i] = '0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        testAluOps();
        testMulDiv();
        testBypass();
        testBranches();
        testJumpsUpper();
        testIllegal();
        $display("Summary: %0d check errors, %0d assertion failures",
                 errors, dut_i.check_i.assertFails);
        if ((errors == 0) && (dut_i.check_i.assertFails == 0)) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/rvIsaPkg.sv
design/corePipePkg.sv
design/controlUnit.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/coreTop.sv
sim/retire_checker.sv
sim/tb.sv
